//--- rtl/ex_params.svh
// Width macros for the execute subsystem
// Data word, register index and ALU op encoding
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Data path width
`define EX_XLEN 32

// Register file index width
`define EX_RADDR_W 5

// ALU operator encoding width
`define EX_ALU_OP_W 4

`endif

//--- rtl/rv_isa_pkg.sv
// RV32 instruction encoding: field types, opcodes and funct values
`default_nettype none

package rv_isa_pkg;

  // Instruction field types
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // Major opcodes used by this subset
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  // funct7 for base, alternate (SUB/SRA) and M extension
  localparam funct7_t F7_BASE   = 7'b0000000;
  localparam funct7_t F7_ALT    = 7'b0100000;
  localparam funct7_t F7_MULDIV = 7'b0000001;

  // CSRRS under SYSTEM
  localparam funct3_t F3_CSRRS = 3'b010;

endpackage

`default_nettype wire

//--- rtl/ex_pipe_pkg.sv
// Pipeline data types: word, register index, ALU and multiplier modes
`default_nettype none

`include "ex_params.svh"

package ex_pipe_pkg;

  typedef logic [`EX_XLEN-1:0]    word_t;
  typedef logic [`EX_RADDR_W-1:0] reg_addr_t;

  // ALU ops; the last six are branch compares
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA,
    OR, AND, EQ, NE, LT, GE, LTU, GEU
  } alu_op_e;

  // Low word or high word with operand signedness
  typedef enum logic [1:0] {
    MULT_LO,
    MULT_HSS,
    MULT_HSU,
    MULT_HUU
  } mult_mode_e;

endpackage

`default_nettype wire

//--- rtl/id_ex_if.sv
// Decode-to-execute bundle with decoder and execute modports
`default_nettype none

interface id_ex_if;
  import ex_pipe_pkg::*;

  // ALU controls and operands, operand_c is the branch target
  alu_op_e    alu_op;
  word_t      operand_a;
  word_t      operand_b;
  word_t      operand_c;

  // Multiplier
  logic       mult_en;
  mult_mode_e mult_mode;

  // Branch and CSR
  logic       branch;
  logic       csr_access;
  word_t      csr_rdata;

  // Register write-back
  logic       rf_we;
  reg_addr_t  rf_waddr;

  modport drv (
    output alu_op, operand_a, operand_b, operand_c,
    output mult_en, mult_mode, branch, csr_access, csr_rdata,
    output rf_we, rf_waddr
  );

  modport ex (
    input alu_op, operand_a, operand_b, operand_c,
    input mult_en, mult_mode, branch, csr_access, csr_rdata,
    input rf_we, rf_waddr
  );

endinterface

`default_nettype wire

//--- rtl/ex_alu.sv
// ALU with shared adder, barrel shifter, logic ops and branch compare
`default_nettype none

`include "ex_params.svh"

module ex_alu (
  input  ex_pipe_pkg::alu_op_e operator_i,
  input  ex_pipe_pkg::word_t   operand_a_i,
  input  ex_pipe_pkg::word_t   operand_b_i,
  output ex_pipe_pkg::word_t   result_o,
  output logic                 cmp_result_o
);
  import ex_pipe_pkg::*;

  logic               sub;
  word_t              adder_b;
  logic [`EX_XLEN:0]  sum;
  logic               eq;
  logic               lt_s;
  logic               lt_u;
  logic [4:0]         shamt;
  logic [`EX_XLEN:0]  shr_in;
  logic [`EX_XLEN:0]  shr_res;

  //////////////////////////////////////////////////
  // Adder, also used as subtractor for compares
  //////////////////////////////////////////////////
  assign sub     = (operator_i != ADD);
  assign adder_b = sub ? ~operand_b_i : operand_b_i;
  assign sum     = {1'b0, operand_a_i} + {1'b0, adder_b} + {{`EX_XLEN{1'b0}}, sub};

  // Flags from the difference
  assign eq   = (sum[`EX_XLEN-1:0] == '0);
  // No carry out means a borrow, so a < b unsigned
  assign lt_u = ~sum[`EX_XLEN];
  assign lt_s = (operand_a_i[`EX_XLEN-1] ^ operand_b_i[`EX_XLEN-1]) ?
                operand_a_i[`EX_XLEN-1] : sum[`EX_XLEN-1];

  // Right shifter with a sign bit on top for SRA
  assign shamt   = operand_b_i[4:0];
  assign shr_in  = {(operator_i == SRA) & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign shr_res = $signed(shr_in) >>> shamt;

  always_comb
  begin
    case (operator_i)
      EQ:         cmp_result_o = eq;
      NE:         cmp_result_o = ~eq;
      LT, SLT:    cmp_result_o = lt_s;
      GE:         cmp_result_o = ~lt_s;
      LTU, SLTU:  cmp_result_o = lt_u;
      GEU:        cmp_result_o = ~lt_u;
      default:    cmp_result_o = 1'b0;
    endcase
  end

  // Result select
  always_comb
  begin
    case (operator_i)
      ADD, SUB:  result_o = sum[`EX_XLEN-1:0];
      SLL:       result_o = operand_a_i << shamt;
      SRL, SRA:  result_o = shr_res[`EX_XLEN-1:0];
      XOR:       result_o = operand_a_i ^ operand_b_i;
      OR:        result_o = operand_a_i | operand_b_i;
      AND:       result_o = operand_a_i & operand_b_i;
      // Set-less-than and compares give 0 or 1
      default:   result_o = word_t'(cmp_result_o);
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/ex_mult.sv
// 32x32 multiplier, low word or high word under three signedness modes
`default_nettype none

`include "ex_params.svh"

module ex_mult (
  input  ex_pipe_pkg::mult_mode_e mode_i,
  input  ex_pipe_pkg::word_t      op_a_i,
  input  ex_pipe_pkg::word_t      op_b_i,
  output ex_pipe_pkg::word_t      result_o
);
  import ex_pipe_pkg::*;

  logic signed [`EX_XLEN:0]     a_ext;
  logic signed [`EX_XLEN:0]     b_ext;
  logic signed [2*`EX_XLEN+1:0] prod;

  // Operand a is signed for MULH and MULHSU
  assign a_ext = {((mode_i == MULT_HSS) || (mode_i == MULT_HSU)) & op_a_i[`EX_XLEN-1],
                  op_a_i};
  // Operand b is signed only for MULH
  assign b_ext = {(mode_i == MULT_HSS) & op_b_i[`EX_XLEN-1], op_b_i};

  // Signed 33x33 covers every mode; low word is mode independent
  assign prod = a_ext * b_ext;

  assign result_o = (mode_i == MULT_LO) ? prod[`EX_XLEN-1:0]
                                        : prod[2*`EX_XLEN-1:`EX_XLEN];

endmodule

`default_nettype wire

//--- rtl/ex_decoder.sv
// Instruction decoder for the OP, OP-IMM, M, BRANCH and CSR read subset
`default_nettype none

`include "ex_params.svh"

module ex_decoder (
  input  logic [31:0]        instr_i,
  input  ex_pipe_pkg::word_t rs1_data_i,
  input  ex_pipe_pkg::word_t rs2_data_i,
  input  ex_pipe_pkg::word_t pc_i,
  input  ex_pipe_pkg::word_t csr_rdata_i,
  output logic               illegal_o,
  id_ex_if.drv               dec
);
  import rv_isa_pkg::*;
  import ex_pipe_pkg::*;

  opcode_t   opcode;
  funct3_t   funct3;
  funct7_t   funct7;
  reg_addr_t rd;
  reg_addr_t rs1;
  word_t     imm_i;
  word_t     imm_b;
  logic      illegal;
  logic      we;

  //////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////
  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign funct7 = instr_i[31:25];

  // Sign-extended immediates
  assign imm_i = {{(`EX_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_b = {{(`EX_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                  instr_i[30:25], instr_i[11:8], 1'b0};

  //////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////
  always_comb
  begin
    // Defaults describe a register-register ALU op
    dec.alu_op     = ADD;
    dec.operand_a  = rs1_data_i;
    dec.operand_b  = rs2_data_i;
    dec.operand_c  = pc_i + imm_b;
    dec.mult_mode  = MULT_LO;
    dec.csr_rdata  = csr_rdata_i;
    dec.rf_waddr   = rd;
    dec.mult_en    = 1'b0;
    dec.branch     = 1'b0;
    dec.csr_access = 1'b0;
    illegal        = 1'b0;
    we             = 1'b0;

    case (opcode)
      OPC_OP:
      begin
        if (funct7 == F7_MULDIV)
        begin
          // Division is not supported
          illegal     = funct3[2];
          dec.mult_en = 1'b1;
          we          = 1'b1;
          case (funct3[1:0])
            2'b00:   dec.mult_mode = MULT_LO;
            2'b01:   dec.mult_mode = MULT_HSS;
            2'b10:   dec.mult_mode = MULT_HSU;
            default: dec.mult_mode = MULT_HUU;
          endcase
        end
        else if (funct7 == F7_BASE ||
                 (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)))
        begin
          we = 1'b1;
          case (funct3)
            3'b000:  dec.alu_op = (funct7 == F7_ALT) ? SUB : ADD;
            3'b001:  dec.alu_op = SLL;
            3'b010:  dec.alu_op = SLT;
            3'b011:  dec.alu_op = SLTU;
            3'b100:  dec.alu_op = XOR;
            3'b101:  dec.alu_op = (funct7 == F7_ALT) ? SRA : SRL;
            3'b110:  dec.alu_op = OR;
            default: dec.alu_op = AND;
          endcase
        end
        else
          illegal = 1'b1;
      end

      OPC_OP_IMM:
      begin
        we            = 1'b1;
        dec.operand_b = imm_i;
        case (funct3)
          3'b000:  dec.alu_op = ADD;
          3'b010:  dec.alu_op = SLT;
          3'b011:  dec.alu_op = SLTU;
          3'b100:  dec.alu_op = XOR;
          3'b110:  dec.alu_op = OR;
          3'b111:  dec.alu_op = AND;
          3'b001:
          begin
            // Shift amount only, upper bits must be zero
            dec.operand_b = word_t'(instr_i[24:20]);
            dec.alu_op    = SLL;
            illegal       = (funct7 != F7_BASE);
          end
          default:
          begin
            dec.operand_b = word_t'(instr_i[24:20]);
            dec.alu_op    = (funct7 == F7_ALT) ? SRA : SRL;
            illegal       = (funct7 != F7_BASE) && (funct7 != F7_ALT);
          end
        endcase
      end

      OPC_BRANCH:
      begin
        dec.branch = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = EQ;
          3'b001:  dec.alu_op = NE;
          3'b100:  dec.alu_op = LT;
          3'b101:  dec.alu_op = GE;
          3'b110:  dec.alu_op = LTU;
          3'b111:  dec.alu_op = GEU;
          default: illegal = 1'b1;
        endcase
      end

      OPC_SYSTEM:
      begin
        // Only a pure CSR read (CSRRS rd, csr, x0)
        if (funct3 == F3_CSRRS && rs1 == '0)
        begin
          dec.csr_access = 1'b1;
          we             = 1'b1;
        end
        else
          illegal = 1'b1;
      end

      default: illegal = 1'b1;
    endcase

    // Illegal encodings must have no side effect
    if (illegal)
    begin
      dec.mult_en    = 1'b0;
      dec.branch     = 1'b0;
      dec.csr_access = 1'b0;
      we             = 1'b0;
    end

    // x0 is never written
    dec.rf_we = we && (rd != '0);
  end

  assign illegal_o = illegal;

endmodule

`default_nettype wire

//--- rtl/ex_stage.sv
// Execute stage: ALU, multiplier, result mux, branch and ready logic
`default_nettype none

module ex_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wb_ready_i,
  id_ex_if.ex                     id,
  output logic                    fw_we_o,
  output ex_pipe_pkg::reg_addr_t  fw_waddr_o,
  output ex_pipe_pkg::word_t      fw_wdata_o,
  output logic                    branch_decision_o,
  output ex_pipe_pkg::word_t      jump_target_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);
  import ex_pipe_pkg::*;

  word_t alu_result;
  logic  alu_cmp_result;
  word_t mult_result;

  //////////////////////////////////////////////////
  // Functional units
  //////////////////////////////////////////////////
  ex_alu alu_i (
    .operator_i   (id.alu_op),
    .operand_a_i  (id.operand_a),
    .operand_b_i  (id.operand_b),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult mult_i (
    .mode_i   (id.mult_mode),
    .op_a_i   (id.operand_a),
    .op_b_i   (id.operand_b),
    .result_o (mult_result)
  );

  // Forwarding bus, CSR wins over multiplier over ALU
  always_comb
  begin
    fw_wdata_o = alu_result;
    if (id.mult_en)
      fw_wdata_o = mult_result;
    if (id.csr_access)
      fw_wdata_o = id.csr_rdata;
  end

  assign fw_we_o    = id.rf_we;
  assign fw_waddr_o = id.rf_waddr;

  // Branch outcome and target
  assign branch_decision_o = id.branch & alu_cmp_result;
  assign jump_target_o     = id.operand_c;

  // Branches never write back, so they proceed under back-pressure
  assign ex_ready_o = wb_ready_i | id.branch;
  assign ex_valid_o = ex_ready_o;

  // Decoder must never select two result sources at once
  a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
    !(id.mult_en && id.csr_access));

endmodule

`default_nettype wire

//--- rtl/ex_wb_reg.sv
// EX/WB pipeline register with load, flush and hold
`default_nettype none

module ex_wb_reg (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ex_valid_i,
  input  logic                   wb_ready_i,
  input  logic                   we_i,
  input  ex_pipe_pkg::reg_addr_t waddr_i,
  input  ex_pipe_pkg::word_t     wdata_i,
  output logic                   wb_we_o,
  output ex_pipe_pkg::reg_addr_t wb_waddr_o,
  output ex_pipe_pkg::word_t     wb_wdata_o
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_we_o    <= 1'b0;
      wb_waddr_o <= '0;
      wb_wdata_o <= '0;
    end
    else if (ex_valid_i)
    begin
      wb_we_o    <= we_i;
      wb_waddr_o <= waddr_i;
      wb_wdata_o <= wdata_i;
    end
    else if (wb_ready_i)
      // Nothing new, so drop the write
      wb_we_o <= 1'b0;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  // x0 writes are filtered upstream in the decoder
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    wb_we_o |-> (wb_waddr_o != '0));

  // Stalled cycle keeps the write-back outputs
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!ex_valid_i && !wb_ready_i) |=>
      ($stable(wb_we_o) && $stable(wb_waddr_o) && $stable(wb_wdata_o)));

endmodule

`default_nettype wire

//--- rtl/ex_top.sv
// Execute subsystem top: decoder, execute stage and EX/WB register
`default_nettype none

module ex_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [31:0]            instr_i,
  input  ex_pipe_pkg::word_t     rs1_data_i,
  input  ex_pipe_pkg::word_t     rs2_data_i,
  input  ex_pipe_pkg::word_t     pc_i,
  input  ex_pipe_pkg::word_t     csr_rdata_i,
  input  logic                   wb_ready_i,
  output logic                   fw_we_o,
  output ex_pipe_pkg::reg_addr_t fw_waddr_o,
  output ex_pipe_pkg::word_t     fw_wdata_o,
  output logic                   branch_decision_o,
  output ex_pipe_pkg::word_t     jump_target_o,
  output logic                   illegal_o,
  output logic                   ex_ready_o,
  output logic                   wb_we_o,
  output ex_pipe_pkg::reg_addr_t wb_waddr_o,
  output ex_pipe_pkg::word_t     wb_wdata_o
);

  logic ex_valid;

  // Decoded instruction bundle
  id_ex_if id_ex ();

  ex_decoder decoder_i (
    .instr_i     (instr_i),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .pc_i        (pc_i),
    .csr_rdata_i (csr_rdata_i),
    .illegal_o   (illegal_o),
    .dec         (id_ex.drv)
  );

  ex_stage ex_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .wb_ready_i        (wb_ready_i),
    .id                (id_ex.ex),
    .fw_we_o           (fw_we_o),
    .fw_waddr_o        (fw_waddr_o),
    .fw_wdata_o        (fw_wdata_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid)
  );

  // Write-back register fed from the forwarding bus
  ex_wb_reg wb_reg_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_valid_i (ex_valid),
    .wb_ready_i (wb_ready_i),
    .we_i       (fw_we_o),
    .waddr_i    (fw_waddr_o),
    .wdata_i    (fw_wdata_o),
    .wb_we_o    (wb_we_o),
    .wb_waddr_o (wb_waddr_o),
    .wb_wdata_o (wb_wdata_o)
  );

endmodule

`default_nettype wire

//--- tb/ex_tb.sv
// Directed testbench for the execute subsystem
// Reference model, LCG stimulus, checks and cycle timeout
`default_nettype none

module ex_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_isa_pkg::*;
  import ex_pipe_pkg::*;

  // Test lengths
  localparam int N_ALU = 800;
  localparam int N_MUL = 24;
  localparam int N_CSR = 8;
  // Reset, ALU, MUL, branch, CSR, back-pressure and illegal cycles
  localparam int TEST_CYCLES = 4 + N_ALU + 4 * (N_MUL + 4) + 6 * 4 + N_CSR + 8 + 6;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

  // Multiplier corner operands
  localparam word_t CORNER_A[4] = '{32'h80000000, 32'h80000000, 32'hFFFFFFFF, 32'hFFFFFFFF};
  localparam word_t CORNER_B[4] = '{32'h80000000, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'h80000000};

  // Branch funct3 values and equal, less, signed-less, greater operand pairs
  localparam logic [2:0] BR_F3[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  localparam word_t PAIR_A[4] = '{32'h12345678, 32'd3, 32'hFFFFFFF0, 32'd7};
  localparam word_t PAIR_B[4] = '{32'h12345678, 32'd7, 32'd5, 32'd3};

  // DIV, bad funct7, opcode 0, CSRRW, CSRRS with rs1, SLLI with funct7 set
  localparam logic [31:0] ILLEGAL[6] = '{
    {F7_MULDIV, 5'd2, 5'd1, 3'b100, 5'd7, OPC_OP},
    {7'h10, 5'd2, 5'd1, 3'b000, 5'd7, OPC_OP},
    {25'h0ABCDE, 7'b0000000},
    {12'h300, 5'd0, 3'b001, 5'd7, OPC_SYSTEM},
    {12'h300, 5'd3, F3_CSRRS, 5'd7, OPC_SYSTEM},
    {F7_ALT, 5'd4, 5'd1, 3'b001, 5'd7, OPC_OP_IMM}
  };

  logic        clk;
  logic        rst_n;
  logic [31:0] instr;
  word_t       rs1_data;
  word_t       rs2_data;
  word_t       pc;
  word_t       csr_rdata;
  logic        wb_ready;
  logic        fw_we;
  reg_addr_t   fw_waddr;
  word_t       fw_wdata;
  logic        branch_decision;
  word_t       jump_target;
  logic        illegal;
  logic        ex_ready;
  logic        wb_we;
  reg_addr_t   wb_waddr;
  word_t       wb_wdata;
  word_t       rand_state;
  int          cycles;

  ex_top dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_i           (instr),
    .rs1_data_i        (rs1_data),
    .rs2_data_i        (rs2_data),
    .pc_i              (pc),
    .csr_rdata_i       (csr_rdata),
    .wb_ready_i        (wb_ready),
    .fw_we_o           (fw_we),
    .fw_waddr_o        (fw_waddr),
    .fw_wdata_o        (fw_wdata),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .illegal_o         (illegal),
    .ex_ready_o        (ex_ready),
    .wb_we_o           (wb_we),
    .wb_waddr_o        (wb_waddr),
    .wb_wdata_o        (wb_wdata)
  );

  always #10 clk = ~clk;

  // Run limit
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////
  function automatic word_t next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    // Fold the upper half down, low LCG bits are weak
    return rand_state ^ {16'h0000, rand_state[31:16]};
  endfunction

  function automatic logic [31:0] encode_r(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd);
    return {f7, 5'd2, 5'd1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] encode_i(logic [11:0] imm, logic [2:0] f3, reg_addr_t rd);
    return {imm, 5'd1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] encode_b(logic [12:0] imm, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  // RV32I integer result for funct3 with the SUB/SRA bit
  function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
    logic signed [31:0] sa;
    logic [4:0]         sh;
    sa = a;
    sh = b[4:0];
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return {31'd0, sa < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5:
      begin
        if (alt)
          return sa >>> sh;
        else
          return a >> sh;
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // 64-bit product, low word for MUL and high word otherwise
  function automatic word_t mul_model(logic [1:0] f3, word_t a, word_t b);
    logic [63:0] xa;
    logic [63:0] xb;
    logic [63:0] prod;
    case (f3)
      2'd1:
      begin
        xa = {{32{a[31]}}, a};
        xb = {{32{b[31]}}, b};
      end
      2'd2:
      begin
        xa = {{32{a[31]}}, a};
        xb = {32'd0, b};
      end
      default:
      begin
        xa = {32'd0, a};
        xb = {32'd0, b};
      end
    endcase
    prod = xa * xb;
    return (f3 == 2'd0) ? prod[31:0] : prod[63:32];
  endfunction

  function automatic logic branch_model(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Check helpers
  //////////////////////////////////////////////////
  task automatic check_equal(string name, word_t got, word_t exp);
    assert (got === exp)
    else
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "value check");
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    assert (got === exp)
    else
    begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "bit check");
    end
  endtask

  // Next drive point, just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_instr(logic [31:0] i, word_t a, word_t b);
    instr    = i;
    rs1_data = a;
    rs2_data = b;
  endtask

  // Forwarding mid-cycle, then write-back after the edge
  task automatic expect_write(reg_addr_t rd, word_t data, logic we);
    #8;
    check_bit("illegal_o", illegal, 1'b0);
    check_bit("ex_ready_o", ex_ready, 1'b1);
    check_bit("fw_we_o", fw_we, we);
    check_equal("fw_waddr_o", word_t'(fw_waddr), word_t'(rd));
    check_equal("fw_wdata_o", fw_wdata, data);
    next_cycle();
    check_bit("wb_we_o", wb_we, we);
    check_equal("wb_waddr_o", word_t'(wb_waddr), word_t'(rd));
    check_equal("wb_wdata_o", wb_wdata, data);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  task automatic test_reset_values();
    check_bit("wb_we_o", wb_we, 1'b0);
    check_equal("wb_waddr_o", word_t'(wb_waddr), 32'd0);
    check_equal("wb_wdata_o", wb_wdata, 32'd0);
  endtask

  task automatic test_alu_random();
    word_t       r;
    word_t       a;
    word_t       b;
    logic [2:0]  f3;
    logic        alt;
    logic        use_imm;
    reg_addr_t   rd;
    logic [11:0] imm;
    logic [31:0] i;
    wb_ready = 1'b1;
    for (int n = 0; n < N_ALU; n++)
    begin
      r       = next_rand();
      a       = next_rand();
      b       = next_rand();
      f3      = r[2:0];
      use_imm = r[3];
      rd      = r[8:4];
      // SUB only exists as a register op
      alt     = r[9] && (f3 == 3'd5 || (f3 == 3'd0 && !use_imm));
      if (use_imm)
      begin
        if (f3 == 3'd1 || f3 == 3'd5)
        begin
          imm = {1'b0, alt, 5'd0, b[4:0]};
          b   = {27'd0, b[4:0]};
        end
        else
        begin
          imm = b[11:0];
          b   = {{20{imm[11]}}, imm};
        end
        i = encode_i(imm, f3, rd);
        apply_instr(i, a, r);
      end
      else
      begin
        i = encode_r({1'b0, alt, 5'd0}, f3, rd);
        apply_instr(i, a, b);
      end
      expect_write(rd, alu_model(f3, alt, a, b), rd != 5'd0);
    end
  endtask

  task automatic test_mult();
    word_t     a;
    word_t     b;
    reg_addr_t rd;
    for (int f = 0; f < 4; f++)
    begin
      for (int n = 0; n < N_MUL + 4; n++)
      begin
        if (n < 4)
        begin
          a = CORNER_A[n];
          b = CORNER_B[n];
        end
        else
        begin
          a = next_rand();
          b = next_rand();
        end
        rd = reg_addr_t'(n % 31 + 1);
        apply_instr(encode_r(F7_MULDIV, 3'(f), rd), a, b);
        expect_write(rd, mul_model(2'(f), a, b), 1'b1);
      end
    end
  endtask

  task automatic test_branches();
    word_t       r;
    logic [12:0] imm;
    // Branches must go ahead even with write-back stalled
    wb_ready = 1'b0;
    for (int k = 0; k < 6; k++)
    begin
      for (int p = 0; p < 4; p++)
      begin
        r   = next_rand();
        imm = {r[11:0], 1'b0};
        pc  = {r[31:14], 14'd0};
        apply_instr(encode_b(imm, BR_F3[k]), PAIR_A[p], PAIR_B[p]);
        #8;
        check_bit("illegal_o", illegal, 1'b0);
        check_bit("branch_decision_o", branch_decision,
                  branch_model(BR_F3[k], PAIR_A[p], PAIR_B[p]));
        check_equal("jump_target_o", jump_target, pc + {{19{imm[12]}}, imm});
        check_bit("ex_ready_o", ex_ready, 1'b1);
        check_bit("fw_we_o", fw_we, 1'b0);
        next_cycle();
        check_bit("wb_we_o", wb_we, 1'b0);
      end
    end
    wb_ready = 1'b1;
  endtask

  task automatic test_csr_read();
    word_t     r;
    reg_addr_t rd;
    for (int n = 0; n < N_CSR; n++)
    begin
      r         = next_rand();
      rd        = reg_addr_t'(n + 1);
      csr_rdata = next_rand();
      apply_instr({r[31:20], 5'd0, F3_CSRRS, rd, OPC_SYSTEM}, r, ~r);
      expect_write(rd, csr_rdata, 1'b1);
    end
  endtask

  task automatic test_backpressure();
    word_t a;
    word_t b;
    // Known write in flight before the stall
    apply_instr(encode_i(12'h123, 3'd0, 5'd5), 32'h1000, 32'd0);
    expect_write(5'd5, alu_model(3'd0, 1'b0, 32'h1000, 32'h123), 1'b1);
    a = next_rand();
    b = next_rand();
    wb_ready = 1'b0;
    apply_instr(encode_r(F7_BASE, 3'd4, 5'd9), a, b);
    repeat (3)
    begin
      #8;
      check_bit("ex_ready_o", ex_ready, 1'b0);
      next_cycle();
      check_bit("wb_we_o", wb_we, 1'b1);
      check_equal("wb_waddr_o", word_t'(wb_waddr), 32'd5);
      check_equal("wb_wdata_o", wb_wdata, 32'h1123);
    end
    // Release, the held XOR goes through
    wb_ready = 1'b1;
    expect_write(5'd9, alu_model(3'd4, 1'b0, a, b), 1'b1);
  endtask

  task automatic test_illegal();
    wb_ready = 1'b1;
    for (int k = 0; k < 6; k++)
    begin
      apply_instr(ILLEGAL[k], next_rand(), next_rand());
      #8;
      check_bit("illegal_o", illegal, 1'b1);
      check_bit("fw_we_o", fw_we, 1'b0);
      next_cycle();
      check_bit("wb_we_o", wb_we, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    // ADDI x0, x0, 0
    instr      = 32'h00000013;
    rs1_data   = '0;
    rs2_data   = '0;
    pc         = '0;
    csr_rdata  = '0;
    wb_ready   = 1'b1;
    rand_state = 32'd6908;
    cycles     = 0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset_values();
    test_alu_random();
    test_mult();
    test_branches();
    test_csr_read();
    test_backpressure();
    test_illegal();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/ex_pipe_pkg.sv
rtl/id_ex_if.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_decoder.sv
rtl/ex_stage.sv
rtl/ex_wb_reg.sv
rtl/ex_top.sv
tb/ex_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f all.f --top-module ex_tb --Mdir obj_dir \
  && ./obj_dir/Vex_tb | tee /dev/stderr | grep -q "Simulation PASSED" \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
